/* common/trigEff_params.svh */
`ifndef TRIGEFF_PARAMS_SVH
`define TRIGEFF_PARAMS_SVH

// Width of every count word and of CptMax
`define CPT_WIDTH 16

// Discriminator trigger outputs per ASIC
`define NUM_TRIG 3

// First word of every test record
`define HEADER_WORD 16'h4343

// Acceptance window in Clk cycles, picked by TriggerDelay
`define WIN_SHORT 4'd4
`define WIN_LONG 4'd8

// Header plus pulse and trigger count per channel
`define NUM_WORDS 7

`endif

/* common/TrigTestPkg.sv */
`default_nettype none

`include "trigEff_params.svh"

package TrigTestPkg;

    ////////////////////////////////////////////////////////////
    // Test sequencing
    ////////////////////////////////////////////////////////////

    typedef enum logic [2:0] {
        IDLE,
        SEND_HEADER,
        TEST_START,
        TEST_RUN,
        CAPTURE,
        READOUT,
        ALL_DONE
    } testState_e;

    // Captured from the host side when a test starts
    typedef struct packed {
        logic [`CPT_WIDTH-1:0] cptMax;
        logic                  triggerDelay;
    } testConfig_t;

    // Low delay setting gives the short window
    function automatic logic [3:0] windowLength(input testConfig_t cfg);
        logic [3:0] len;
        len = cfg.triggerDelay ? `WIN_LONG : `WIN_SHORT;
        return len;
    endfunction

endpackage

`default_nettype wire

/* common/CountDataPkg.sv */
`default_nettype none

`include "trigEff_params.svh"

package CountDataPkg;

    // Single-cycle edge flags in the Clk domain
    typedef struct packed {
        logic                 extPulse;
        logic [`NUM_TRIG-1:0] trigHit;
    } feEvents_t;

    // Results of one channel
    typedef struct packed {
        logic [`CPT_WIDTH-1:0] pulseCount;
        logic [`CPT_WIDTH-1:0] trigCount;
    } chanCount_t;

    ////////////////////////////////////////////////////////////
    // Output word stream
    ////////////////////////////////////////////////////////////

    typedef struct packed {
        logic [`CPT_WIDTH-1:0] data;
        logic                  valid;
    } dataWord_t;

endpackage

`default_nettype wire

/* design/triggerCounter/TriggerSync.sv */
`default_nettype none
`timescale 1ns/1ps

`include "trigEff_params.svh"

module TriggerSync
    import CountDataPkg::*;
(
    input  wire logic                 Clk,
    input  wire logic                 reset_n,
    input  wire logic                 ClkExt,
    input  wire logic [`NUM_TRIG-1:0] TrigInB,
    output feEvents_t                 Events
);

    // Idle levels of the lines, strobe low and triggers high
    localparam logic [`NUM_TRIG:0] IDLE_LEVEL = {1'b0, {`NUM_TRIG{1'b1}}};

    logic [`NUM_TRIG:0] lineIn;
    logic [`NUM_TRIG:0] meta;
    logic [`NUM_TRIG:0] sync;
    logic [`NUM_TRIG:0] last;
    logic [`NUM_TRIG:0] edgeSeen;

    assign lineIn = {ClkExt, TrigInB};

    // Rising edge for the strobe, falling edge for the active-low triggers
    assign edgeSeen[`NUM_TRIG]     = sync[`NUM_TRIG] & ~last[`NUM_TRIG];
    assign edgeSeen[`NUM_TRIG-1:0] = ~sync[`NUM_TRIG-1:0] & last[`NUM_TRIG-1:0];

    always_ff @(posedge Clk or negedge reset_n) begin
        if (!reset_n) begin
            meta   <= IDLE_LEVEL;
            sync   <= IDLE_LEVEL;
            last   <= IDLE_LEVEL;
            Events <= '0;
        end else begin
            meta   <= lineIn;
            sync   <= meta;
            last   <= sync;
            // Same latency on every line keeps pulse to trigger spacing intact
            Events <= feEvents_t'(edgeSeen);
        end
    end

endmodule

`default_nettype wire

/* design/triggerCounter/ScurveChannelCounter.sv */
`default_nettype none
`timescale 1ns/1ps

`include "trigEff_params.svh"

module ScurveChannelCounter
    import TrigTestPkg::*;
    import CountDataPkg::*;
(
    input  wire logic  Clk,
    input  wire logic  reset_n,
    input  wire testConfig_t Cfg,
    input  wire logic  CountStart,
    input  wire logic  ClearCounts,
    input  wire logic  ExtPulse,
    input  wire logic  TrigHit,
    output chanCount_t Counts,
    output logic       CountDone
);

    logic [`CPT_WIDTH-1:0] pulseCount;
    logic [`CPT_WIDTH-1:0] trigCount;
    logic [3:0]            winCount;
    logic                  armed;
    logic                  running;
    logic                  windowOpen;
    logic                  pulseAccepted;
    logic                  hitAccepted;

    assign windowOpen    = (winCount != 4'd0);
    // Pulses beyond cptMax are ignored
    assign pulseAccepted = running && ExtPulse && (pulseCount < Cfg.cptMax);
    // Only the first trigger of a window counts
    assign hitAccepted   = running && TrigHit && armed && windowOpen;

    ////////////////////////////////////////////////////////////
    // Counters and acceptance window
    ////////////////////////////////////////////////////////////

    always_ff @(posedge Clk or negedge reset_n) begin
        if (!reset_n) begin
            pulseCount <= '0;
            trigCount  <= '0;
            winCount   <= 4'd0;
            armed      <= 1'b0;
            running    <= 1'b0;
            CountDone  <= 1'b0;
        end else if (ClearCounts) begin
            pulseCount <= '0;
            trigCount  <= '0;
            winCount   <= 4'd0;
            armed      <= 1'b0;
            running    <= 1'b0;
            CountDone  <= 1'b0;
        end else if (CountStart) begin
            pulseCount <= '0;
            trigCount  <= '0;
            winCount   <= 4'd0;
            armed      <= 1'b0;
            running    <= 1'b1;
            CountDone  <= 1'b0;
        end else begin
            // A new pulse restarts the window
            if (pulseAccepted) begin
                if (pulseCount != '1) begin
                    pulseCount <= pulseCount + 1'b1;
                end
                winCount <= windowLength(Cfg);
            end else if (windowOpen) begin
                winCount <= winCount - 1'b1;
            end

            if (hitAccepted && (trigCount != '1)) begin
                trigCount <= trigCount + 1'b1;
            end

            if (pulseAccepted) begin
                armed <= 1'b1;
            end else if (hitAccepted || (winCount == 4'd1)) begin
                armed <= 1'b0;
            end

            // Sticky until the next clear
            if (running && !windowOpen && (pulseCount == Cfg.cptMax)) begin
                CountDone <= 1'b1;
            end
        end
    end

    assign Counts = '{pulseCount: pulseCount, trigCount: trigCount};

endmodule

`default_nettype wire

/* design/ResultSerializer.sv */
`default_nettype none
`timescale 1ns/1ps

`include "trigEff_params.svh"

module ResultSerializer
    import CountDataPkg::*;
(
    input  wire logic                   Clk,
    input  wire logic                   reset_n,
    input  wire logic                   LoadHeader,
    input  wire logic                   LoadCounts,
    input  wire chanCount_t [`NUM_TRIG-1:0] AllCounts,
    input  wire logic                   DataReady,
    output dataWord_t                   Word,
    output logic                        SendDone
);

    localparam int COUNT_WORDS = `NUM_WORDS - 1;

    logic [COUNT_WORDS-1:0][`CPT_WIDTH-1:0] ordered;
    logic [COUNT_WORDS-2:0][`CPT_WIDTH-1:0] pending;
    logic [`CPT_WIDTH-1:0]                  wordData;
    logic                                   wordValid;
    logic [2:0]                             wordsLeft;
    logic                                   accepted;

    // Pulse0, Trig0, Pulse1, Trig1, Pulse2, Trig2
    always_comb begin
        for (int ch = 0; ch < `NUM_TRIG; ch++) begin
            ordered[2*ch]   = AllCounts[ch].pulseCount;
            ordered[2*ch+1] = AllCounts[ch].trigCount;
        end
    end

    assign accepted = wordValid && DataReady;

    ////////////////////////////////////////////////////////////
    // Word queue control
    ////////////////////////////////////////////////////////////

    always_ff @(posedge Clk or negedge reset_n) begin
        if (!reset_n) begin
            wordValid <= 1'b0;
            wordsLeft <= 3'd0;
            SendDone  <= 1'b0;
        end else begin
            SendDone <= 1'b0;
            if (LoadHeader) begin
                wordValid <= 1'b1;
                wordsLeft <= 3'd1;
            end else if (LoadCounts) begin
                wordValid <= 1'b1;
                wordsLeft <= 3'(COUNT_WORDS);
            end else if (accepted) begin
                wordsLeft <= wordsLeft - 1'b1;
                if (wordsLeft == 3'd1) begin
                    wordValid <= 1'b0;
                    SendDone  <= 1'b1;
                end
            end
        end
    end

    // Data only moves on load or acceptance so it holds while stalled
    always_ff @(posedge Clk) begin
        if (LoadHeader) begin
            wordData <= `HEADER_WORD;
        end else if (LoadCounts) begin
            wordData <= ordered[0];
            pending  <= ordered[COUNT_WORDS-1:1];
        end else if (accepted && (wordsLeft != 3'd1)) begin
            wordData <= pending[0];
            pending  <= pending >> `CPT_WIDTH;
        end
    end

    assign Word = '{data: wordData, valid: wordValid};

endmodule

`default_nettype wire

/* design/TrigEfficiencyTest.sv */
`default_nettype none
`timescale 1ns/1ps

`include "trigEff_params.svh"

module TrigEfficiencyTest
    import TrigTestPkg::*;
(
    input  wire logic                  Clk,
    input  wire logic                  reset_n,
    input  wire logic                  Start,
    input  wire logic [`CPT_WIDTH-1:0] CptMax,
    input  wire logic                  TriggerDelay,
    input  wire logic [`NUM_TRIG-1:0]  ChanDone,
    input  wire logic                  SendDone,
    input  wire logic                  DataTransmitDone,
    output testConfig_t                Cfg,
    output logic                       CountStart,
    output logic                       ClearCounts,
    output logic                       LoadHeader,
    output logic                       LoadCounts,
    output logic                       TestDone
);

    testState_e state;

    ////////////////////////////////////////////////////////////
    // Test sequencing FSM
    ////////////////////////////////////////////////////////////

    always_ff @(posedge Clk or negedge reset_n) begin
        if (!reset_n) begin
            state       <= IDLE;
            Cfg         <= '0;
            CountStart  <= 1'b0;
            ClearCounts <= 1'b1;
            LoadHeader  <= 1'b0;
            LoadCounts  <= 1'b0;
            TestDone    <= 1'b0;
        end else begin
            // Strobes last one cycle
            CountStart <= 1'b0;
            LoadHeader <= 1'b0;
            LoadCounts <= 1'b0;

            case (state)
                IDLE: begin
                    if (Start) begin
                        Cfg         <= '{cptMax: CptMax, triggerDelay: TriggerDelay};
                        LoadHeader  <= 1'b1;
                        ClearCounts <= 1'b0;
                        state       <= SEND_HEADER;
                    end
                end
                SEND_HEADER: begin
                    // Counting waits for the header to leave
                    if (SendDone) begin
                        CountStart <= 1'b1;
                        state      <= TEST_START;
                    end
                end
                TEST_START: begin
                    state <= TEST_RUN;
                end
                TEST_RUN: begin
                    if (&ChanDone) begin
                        LoadCounts <= 1'b1;
                        state      <= CAPTURE;
                    end
                end
                CAPTURE: begin
                    state <= READOUT;
                end
                READOUT: begin
                    if (SendDone) begin
                        TestDone <= 1'b1;
                        state    <= ALL_DONE;
                    end
                end
                ALL_DONE: begin
                    // Host confirms the record went out
                    if (DataTransmitDone) begin
                        TestDone    <= 1'b0;
                        ClearCounts <= 1'b1;
                        state       <= IDLE;
                    end
                end
                default: begin
                    ClearCounts <= 1'b1;
                    TestDone    <= 1'b0;
                    state       <= IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* design/TrigEfficiencyTop.sv */
`default_nettype none
`timescale 1ns/1ps

`include "trigEff_params.svh"

module TrigEfficiencyTop
    import TrigTestPkg::*;
    import CountDataPkg::*;
(
    input  wire logic                  Clk,
    input  wire logic                  reset_n,
    input  wire logic                  ClkExt,
    input  wire logic                  OutTrigger0b,
    input  wire logic                  OutTrigger1b,
    input  wire logic                  OutTrigger2b,
    input  wire logic                  Start,
    input  wire logic [`CPT_WIDTH-1:0] CptMax,
    input  wire logic                  TriggerDelay,
    input  wire logic                  DataReady,
    input  wire logic                  DataTransmitDone,
    output logic [`CPT_WIDTH-1:0]      TrigEfficiencyData,
    output logic                       TrigEfficiencyDataEn,
    output logic                       TestDone
);

    feEvents_t                 events;
    testConfig_t               cfg;
    chanCount_t [`NUM_TRIG-1:0] allCounts;
    logic [`NUM_TRIG-1:0]      chanDone;
    dataWord_t                 word;
    logic                      countStart;
    logic                      clearCounts;
    logic                      loadHeader;
    logic                      loadCounts;
    logic                      sendDone;

    TriggerSync uSync (
        .Clk     (Clk),
        .reset_n (reset_n),
        .ClkExt  (ClkExt),
        .TrigInB ({OutTrigger2b, OutTrigger1b, OutTrigger0b}),
        .Events  (events)
    );

    // One counter per discriminator output, all fed by the same strobe
    for (genvar ch = 0; ch < `NUM_TRIG; ch++) begin : gChannel
        ScurveChannelCounter uCounter (
            .Clk         (Clk),
            .reset_n     (reset_n),
            .Cfg         (cfg),
            .CountStart  (countStart),
            .ClearCounts (clearCounts),
            .ExtPulse    (events.extPulse),
            .TrigHit     (events.trigHit[ch]),
            .Counts      (allCounts[ch]),
            .CountDone   (chanDone[ch])
        );
    end

    ResultSerializer uSerializer (
        .Clk        (Clk),
        .reset_n    (reset_n),
        .LoadHeader (loadHeader),
        .LoadCounts (loadCounts),
        .AllCounts  (allCounts),
        .DataReady  (DataReady),
        .Word       (word),
        .SendDone   (sendDone)
    );

    TrigEfficiencyTest uControl (
        .Clk              (Clk),
        .reset_n          (reset_n),
        .Start            (Start),
        .CptMax           (CptMax),
        .TriggerDelay     (TriggerDelay),
        .ChanDone         (chanDone),
        .SendDone         (sendDone),
        .DataTransmitDone (DataTransmitDone),
        .Cfg              (cfg),
        .CountStart       (countStart),
        .ClearCounts      (clearCounts),
        .LoadHeader       (loadHeader),
        .LoadCounts       (loadCounts),
        .TestDone         (TestDone)
    );

    assign TrigEfficiencyData   = word.data;
    assign TrigEfficiencyDataEn = word.valid;

endmodule

`default_nettype wire

/* verification/TrigEfficiencyTb.sv */
`default_nettype none
`timescale 1ns/1ps

`include "trigEff_params.svh"

module TrigEfficiencyTb;

    localparam int MAX_PULSES    = 16;
    localparam int PULSE_SPACING = 16;
    // Every scripted pulse over all runs including the extra ones
    localparam int TOTAL_PULSES  = 35;
    localparam int NUM_RUNS      = 7;
    localparam int CYCLE_LIMIT   = TOTAL_PULSES * PULSE_SPACING + NUM_RUNS * 200;

    logic                  Clk;
    logic                  reset_n;
    logic                  ClkExt;
    logic                  OutTrigger0b;
    logic                  OutTrigger1b;
    logic                  OutTrigger2b;
    logic                  Start;
    logic [`CPT_WIDTH-1:0] CptMax;
    logic                  TriggerDelay;
    logic                  DataReady;
    logic                  DataTransmitDone;
    logic [`CPT_WIDTH-1:0] TrigEfficiencyData;
    logic                  TrigEfficiencyDataEn;
    logic                  TestDone;

    // Pulse script with the answering triggers, their delays and the gap to the next pulse
    logic [2:0]  respMask [MAX_PULSES];
    int          respDelay [MAX_PULSES][3];
    int          pulseGap [MAX_PULSES];
    int          checkCount;
    int          errorCount;
    int          cycleCount = 0;
    logic [31:0] lcgState;

    TrigEfficiencyTop dut (
        .Clk                  (Clk),
        .reset_n              (reset_n),
        .ClkExt               (ClkExt),
        .OutTrigger0b         (OutTrigger0b),
        .OutTrigger1b         (OutTrigger1b),
        .OutTrigger2b         (OutTrigger2b),
        .Start                (Start),
        .CptMax               (CptMax),
        .TriggerDelay         (TriggerDelay),
        .DataReady            (DataReady),
        .DataTransmitDone     (DataTransmitDone),
        .TrigEfficiencyData   (TrigEfficiencyData),
        .TrigEfficiencyDataEn (TrigEfficiencyDataEn),
        .TestDone             (TestDone)
    );

    initial begin
        Clk = 1'b0;
        forever #4 Clk = ~Clk;
    end

    always @(posedge Clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= CYCLE_LIMIT) begin
            $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    function automatic logic [31:0] nextRand();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState;
    endfunction

    task automatic checkValue(input string testName, input string what,
                              input int expected, input int actual);
        checkCount++;
        if (expected !== actual) begin
            $display("[FAIL] %s %s: expected 0x%0h, actual 0x%0h",
                     testName, what, expected, actual);
            errorCount++;
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Pulse and trigger model
    ////////////////////////////////////////////////////////////

    function automatic logic triggerLow(input int p, input int ch, input int k);
        return respMask[p][ch] && (k >= respDelay[p][ch]) && (k < respDelay[p][ch] + 2);
    endfunction

    // Strobe and triggers share the 3 cycle sync so the delay maps straight on the window
    function automatic int expectedTrig(input int numPulses, input int cptMax,
                                        input logic delayHigh, input int ch);
        int winLen;
        int hits;
        winLen = delayHigh ? int'(`WIN_LONG) : int'(`WIN_SHORT);
        hits   = 0;
        for (int p = 0; p < numPulses && p < cptMax; p++) begin
            if (respMask[p][ch] && respDelay[p][ch] <= winLen) begin
                hits++;
            end
        end
        return hits;
    endfunction

    task automatic clearScript();
        for (int p = 0; p < MAX_PULSES; p++) begin
            respMask[p] = 3'b000;
            pulseGap[p] = PULSE_SPACING;
            for (int ch = 0; ch < 3; ch++) begin
                respDelay[p][ch] = 0;
            end
        end
    endtask

    task automatic drivePulses(input int numPulses);
        for (int p = 0; p < numPulses; p++) begin
            for (int k = 0; k < pulseGap[p]; k++) begin
                @(negedge Clk);
                ClkExt       = (k < 2);
                OutTrigger0b = !triggerLow(p, 0, k);
                OutTrigger1b = !triggerLow(p, 1, k);
                OutTrigger2b = !triggerLow(p, 2, k);
            end
        end
    endtask

    // One word off the output under optional random back-pressure
    task automatic collectWord(input string testName, input logic stalls,
                               output logic [`CPT_WIDTH-1:0] data);
        logic [31:0] r;
        logic        holding;
        logic        done;
        holding = 1'b0;
        done    = 1'b0;
        while (!done) begin
            @(negedge Clk);
            if (holding) begin
                checkValue(testName, "valid while stalled", 1, int'(TrigEfficiencyDataEn));
                checkValue(testName, "data while stalled", int'(data), int'(TrigEfficiencyData));
            end
            r         = nextRand();
            DataReady = stalls ? r[22] : 1'b1;
            if (TrigEfficiencyDataEn) begin
                data    = TrigEfficiencyData;
                holding = !DataReady;
                done    = DataReady;
            end
        end
        @(negedge Clk);
        DataReady = 1'b0;
    endtask

    task automatic finishTest(input string testName);
        logic extraSeen;
        extraSeen = 1'b0;
        while (!TestDone) begin
            @(negedge Clk);
            if (TrigEfficiencyDataEn && !extraSeen) begin
                $display("%s: a word came out after the seventh", testName);
                errorCount++;
                extraSeen = 1'b1;
            end
        end
        // Host is slow to confirm
        repeat (6) begin
            @(negedge Clk);
            checkValue(testName, "TestDone held", 1, int'(TestDone));
        end
        DataTransmitDone = 1'b1;
        @(negedge Clk);
        DataTransmitDone = 1'b0;
        checkValue(testName, "TestDone cleared", 0, int'(TestDone));
    endtask

    task automatic runScript(input string testName, input int cptMax, input logic delayHigh,
                             input int numPulses, input logic stalls);
        int                    expPulse;
        int                    expTrig [3];
        int                    errorsBefore;
        logic [`CPT_WIDTH-1:0] word;
        errorsBefore = errorCount;
        expPulse     = (numPulses < cptMax) ? numPulses : cptMax;
        for (int ch = 0; ch < 3; ch++) begin
            expTrig[ch] = expectedTrig(numPulses, cptMax, delayHigh, ch);
        end
        @(negedge Clk);
        CptMax       = `CPT_WIDTH'(cptMax);
        TriggerDelay = delayHigh;
        Start        = 1'b1;
        @(negedge Clk);
        Start = 1'b0;
        collectWord(testName, stalls, word);
        checkValue(testName, "header", int'(`HEADER_WORD), int'(word));
        // Counters start a few cycles after the header is taken
        repeat (2) @(negedge Clk);
        drivePulses(numPulses);
        for (int ch = 0; ch < 3; ch++) begin
            collectWord(testName, stalls, word);
            checkValue(testName, $sformatf("pulse count %0d", ch), expPulse, int'(word));
            collectWord(testName, stalls, word);
            checkValue(testName, $sformatf("trig count %0d", ch), expTrig[ch], int'(word));
        end
        finishTest(testName);
        $display("%s: %s, %0d errors", testName,
                 (errorCount == errorsBefore) ? "ok" : "mismatch", errorCount - errorsBefore);
    endtask

    ////////////////////////////////////////////////////////////
    // Directed tests
    ////////////////////////////////////////////////////////////

    // Distinct counts per channel expose the word order
    task automatic headerOrderTest();
        clearScript();
        for (int p = 0; p < 6; p++) begin
            respMask[p]     = {1'b0, p[0] == 1'b0, 1'b1};
            respDelay[p][0] = 2;
            respDelay[p][1] = 2;
        end
        runScript("headerOrder", 6, 1'b0, 6, 1'b0);
    endtask

    // Extra pulse beyond cptMax lands inside the last counted window
    task automatic fullResponseTest();
        clearScript();
        for (int p = 0; p < 6; p++) begin
            respMask[p] = 3'b111;
            for (int ch = 0; ch < 3; ch++) begin
                respDelay[p][ch] = 2;
            end
        end
        pulseGap[4] = 4;
        runScript("fullResponse", 5, 1'b0, 6, 1'b0);
    endtask

    task automatic delaySelectTest();
        clearScript();
        for (int p = 0; p < 4; p++) begin
            respMask[p] = 3'b111;
            for (int ch = 0; ch < 3; ch++) begin
                respDelay[p][ch] = 6;
            end
        end
        runScript("longWindow", 4, 1'b1, 4, 1'b0);
        runScript("shortWindow", 4, 1'b0, 4, 1'b0);
    endtask

    task automatic randomMixTest();
        logic [31:0] r;
        clearScript();
        for (int p = 0; p < 12; p++) begin
            for (int ch = 0; ch < 3; ch++) begin
                r                = nextRand();
                respMask[p][ch]  = r[20];
                respDelay[p][ch] = r[26] ? 6 : 2;
            end
        end
        runScript("randomMix", 12, 1'b0, 12, 1'b1);
    endtask

    // Follows a longer run so leftover counts would show
    task automatic restartTest();
        clearScript();
        for (int p = 0; p < 3; p++) begin
            respMask[p]     = 3'b101;
            respDelay[p][0] = 2;
            respDelay[p][2] = 2;
        end
        runScript("restart", 3, 1'b0, 3, 1'b1);
    endtask

    task automatic zeroCountTest();
        clearScript();
        runScript("zeroCount", 0, 1'b0, 0, 1'b0);
    endtask

    initial begin
        reset_n          = 1'b0;
        ClkExt           = 1'b0;
        OutTrigger0b     = 1'b1;
        OutTrigger1b     = 1'b1;
        OutTrigger2b     = 1'b1;
        Start            = 1'b0;
        CptMax           = '0;
        TriggerDelay     = 1'b0;
        DataReady        = 1'b0;
        DataTransmitDone = 1'b0;
        checkCount       = 0;
        errorCount       = 0;
        lcgState         = 32'd37064;
        repeat (2) @(negedge Clk);
        reset_n = 1'b1;
        checkValue("reset", "data valid", 0, int'(TrigEfficiencyDataEn));
        checkValue("reset", "TestDone", 0, int'(TestDone));

        headerOrderTest();
        fullResponseTest();
        delaySelectTest();
        randomMixTest();
        restartTest();
        zeroCountTest();

        $display("Summary: %0d checks, %0d errors", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* TrigEfficiencyTop.f */
+incdir+common
common/TrigTestPkg.sv
common/CountDataPkg.sv
design/triggerCounter/TriggerSync.sv
design/triggerCounter/ScurveChannelCounter.sv
design/ResultSerializer.sv
design/TrigEfficiencyTest.sv
design/TrigEfficiencyTop.sv
verification/TrigEfficiencyTb.sv

/* Makefile */
TOOL       = verilator
FLAGS      = --binary --timing -Wno-fatal
LINT_FLAGS = --lint-only --timing -Wall
TOP        = TrigEfficiencyTb
RTL_TOP    = TrigEfficiencyTop
FILELIST   = TrigEfficiencyTop.f
BUILD_DIR  = obj_dir
LOG        = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "ALL CHECKS PASSED" $(LOG) || (echo "Simulation reported failure" && exit 1)

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
